// ==== hw/cdb_defs.svh ====
`ifndef CDB_DEFS_SVH
`define CDB_DEFS_SVH

// Number of execution units feeding the CDB
// Unit 0 is the maximum-priority unit, the others are ordinary units
`define CDB_EU_N 4

// Width of a result word on the bus
`define CDB_XLEN 32

// Width of a reorder buffer index
// Sixteen ROB entries in flight
`define CDB_ROB_IDX_W 4

// Exception cause code width
`define CDB_EXC_CAUSE_W 5

// Trap value takes whatever the cause leaves of the word
// Low bits of the faulting address
`define CDB_EXC_TVAL_W (`CDB_XLEN - `CDB_EXC_CAUSE_W)

`endif

// ==== hw/cdb_pkg.sv ====
`include "cdb_defs.svh"

package cdb_pkg;

    // Index into the reorder buffer
    typedef logic [`CDB_ROB_IDX_W-1:0] rob_idx_t;

    // Index of an ordinary unit on the arbiter side
    // Sized on the full unit count so any buffer number fits
    typedef logic [$clog2(`CDB_EU_N)-1:0] unit_idx_t;

    // Exception record carried in place of a result
    // Cause sits in the low bits of the word
    typedef struct packed {
        logic [`CDB_EXC_TVAL_W-1:0]  tval;
        logic [`CDB_EXC_CAUSE_W-1:0] cause;
    } exc_rec_t;

    // Payload word as seen by the ROB
    // Read through exc when the exception flag is set
    // Otherwise value holds the computed result
    typedef union packed {
        logic [`CDB_XLEN-1:0] value;
        exc_rec_t             exc;
    } cdb_payload_t;

endpackage

// ==== hw/prio_enc.sv ====
`timescale 1ns/100ps

module prio_enc #(
    parameter int unsigned N = 4
) (
    input  logic [N-1:0]         lines_i,
    output logic [$clog2(N)-1:0] enc_o,
    output logic                 valid_o
);

    localparam int unsigned ENC_W = $clog2(N);

    // Scan from the top so the lowest set line is written last
    always_comb begin : enc_scan
        enc_o = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (lines_i[i]) begin
                enc_o = ENC_W'(i);
            end
        end
    end

    // Any request at all
    assign valid_o = |lines_i;

endmodule

// ==== hw/cdb_arbiter.sv ====
`timescale 1ns/100ps
`include "cdb_defs.svh"

module cdb_arbiter (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         flush_i,

    // Maximum-priority unit handshake
    input  logic                         max_prio_valid_i,
    output logic                         max_prio_ready_o,

    // Ordinary unit handshakes
    input  logic [`CDB_EU_N-2:0]         valid_i,
    output logic [`CDB_EU_N-2:0]         ready_o,

    // ROB handshake
    input  logic                         rob_ready_i,
    output logic                         rob_valid_o,

    // Select lines for the CDB data multiplexer
    output logic                         served_max_prio_o,
    output cdb_pkg::unit_idx_t           served_o
);

    localparam int unsigned LINES = `CDB_EU_N - 1;
    localparam int unsigned IDX_W = $clog2(LINES);

    // Requests left over from the current round
    logic [LINES-1:0] rem_valid_q;
    // Set the encoder works on this cycle
    logic [LINES-1:0] mux_valid;
    logic [IDX_W-1:0] enc_idx;
    logic             enc_valid;

    // Grant frozen while the ROB stalls a presented result
    logic             hold_q;
    logic             hold_mp_q;
    logic [IDX_W-1:0] hold_idx_q;

    // Effective grant after the hold
    logic             grant_mp;
    logic             grant_ord;
    logic [IDX_W-1:0] grant_idx;
    logic [LINES-1:0] grant_oh;

    // Round still open, so keep serving what was sampled
    // Empty register means a fresh sample of live requests
    assign mux_valid = (|rem_valid_q) ? rem_valid_q : valid_i;

    prio_enc #(
        .N (LINES)
    ) u_prio_enc (
        .lines_i (mux_valid),
        .enc_o   (enc_idx),
        .valid_o (enc_valid)
    );

    // A stalled result stays on the bus until the ROB takes it
    // Preemption by the maximum-priority line waits for the next decision
    assign grant_mp  = hold_q ? hold_mp_q : max_prio_valid_i;
    assign grant_ord = hold_q ? ~hold_mp_q : (~max_prio_valid_i & enc_valid);
    assign grant_idx = hold_q ? hold_idx_q : enc_idx;

    // One-hot decode of the ordinary grant
    always_comb begin : grant_dec
        grant_oh = '0;
        if (grant_ord) begin
            grant_oh[grant_idx] = 1'b1;
        end
    end

    // Ready goes to the granted source only
    assign max_prio_ready_o = grant_mp & rob_ready_i;
    assign ready_o          = rob_ready_i ? grant_oh : '0;
    assign rob_valid_o      = grant_mp | grant_ord;

    assign served_max_prio_o = grant_mp;
    assign served_o          = cdb_pkg::unit_idx_t'(grant_idx);

    // Round bookkeeping
    // Only a real ordinary transfer removes a line from the round
    always_ff @(posedge clk_i or negedge rst_n_i) begin : rem_reg
        if (!rst_n_i) begin
            rem_valid_q <= '0;
        end else if (flush_i) begin
            rem_valid_q <= '0;
        end else if (grant_ord && rob_ready_i) begin
            rem_valid_q <= mux_valid & ~grant_oh;
        end
    end

    // Remember the grant whenever the bus shows valid without ready
    always_ff @(posedge clk_i or negedge rst_n_i) begin : hold_reg
        if (!rst_n_i) begin
            hold_q     <= 1'b0;
            hold_mp_q  <= 1'b0;
            hold_idx_q <= '0;
        end else if (flush_i) begin
            hold_q     <= 1'b0;
            hold_mp_q  <= 1'b0;
            hold_idx_q <= '0;
        end else begin
            hold_q     <= rob_valid_o & ~rob_ready_i;
            hold_mp_q  <= grant_mp;
            hold_idx_q <= grant_idx;
        end
    end

    // At most one unit is served per cycle, ordinary or maximum-priority
    a_ready_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({ready_o, max_prio_ready_o}))
        else $error("cdb_arbiter: more than one ready bit set");

    // Held grants must still point at a buffer that is holding its result
    a_ready_has_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ready_o & ~valid_i) == '0)
        else $error("cdb_arbiter: ready_o granted to an idle unit");

    // Buffers come out of reset empty
    a_idle_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !rob_valid_o)
        else $error("cdb_arbiter: rob_valid_o high right after reset");

endmodule

// ==== hw/eu_result_buf.sv ====
`timescale 1ns/100ps

module eu_result_buf (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,

    // Execution unit side
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  cdb_pkg::rob_idx_t     in_rob_idx_i,
    input  logic                  in_except_i,
    input  cdb_pkg::cdb_payload_t in_payload_i,

    // Arbiter side
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output cdb_pkg::rob_idx_t     out_rob_idx_o,
    output logic                  out_except_o,
    output cdb_pkg::cdb_payload_t out_payload_o
);

    // Output entry drives the arbiter directly
    logic                  out_valid_q;
    cdb_pkg::rob_idx_t     out_rob_idx_q;
    logic                  out_except_q;
    cdb_pkg::cdb_payload_t out_payload_q;

    // Skid entry catches one result while the output is stalled
    logic                  skid_valid_q;
    cdb_pkg::rob_idx_t     skid_rob_idx_q;
    logic                  skid_except_q;
    cdb_pkg::cdb_payload_t skid_payload_q;

    logic in_fire;
    logic out_fire;
    logic load_out;

    // Unit-side ready comes from a flop only
    assign in_ready_o = ~skid_valid_q;

    assign in_fire  = in_valid_i & in_ready_o;
    assign out_fire = out_valid_q & out_ready_i;
    // Output entry free at this edge
    assign load_out = ~out_valid_q | out_fire;

    always_ff @(posedge clk_i or negedge rst_n_i) begin : ctrl_reg
        if (!rst_n_i) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (flush_i) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (load_out) begin
            // Skid entry drains first, else the new input goes straight out
            out_valid_q  <= skid_valid_q | in_fire;
            skid_valid_q <= 1'b0;
        end else if (in_fire) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin : data_reg
        if (load_out) begin
            if (skid_valid_q) begin
                out_rob_idx_q <= skid_rob_idx_q;
                out_except_q  <= skid_except_q;
                out_payload_q <= skid_payload_q;
            end else begin
                out_rob_idx_q <= in_rob_idx_i;
                out_except_q  <= in_except_i;
                out_payload_q <= in_payload_i;
            end
        end
        if (in_fire && !load_out) begin
            skid_rob_idx_q <= in_rob_idx_i;
            skid_except_q  <= in_except_i;
            skid_payload_q <= in_payload_i;
        end
    end

    assign out_valid_o   = out_valid_q;
    assign out_rob_idx_o = out_rob_idx_q;
    assign out_except_o  = out_except_q;
    assign out_payload_o = out_payload_q;

    // Both entries busy means nothing may be written
    a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_q && skid_valid_q) |-> !in_fire)
        else $error("eu_result_buf: write while full");

endmodule

// ==== hw/cdb_top.sv ====
`timescale 1ns/100ps
`include "cdb_defs.svh"

module cdb_top (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    input  logic                                    flush_i,

    // Maximum-priority unit
    input  logic                                    mp_valid_i,
    output logic                                    mp_ready_o,
    input  cdb_pkg::rob_idx_t                       mp_rob_idx_i,
    input  logic                                    mp_except_i,
    input  cdb_pkg::cdb_payload_t                   mp_payload_i,

    // Ordinary units
    input  logic [`CDB_EU_N-2:0]                    eu_valid_i,
    output logic [`CDB_EU_N-2:0]                    eu_ready_o,
    input  cdb_pkg::rob_idx_t [`CDB_EU_N-2:0]       eu_rob_idx_i,
    input  logic [`CDB_EU_N-2:0]                    eu_except_i,
    input  cdb_pkg::cdb_payload_t [`CDB_EU_N-2:0]   eu_payload_i,

    // ROB side
    output logic                                    cdb_valid_o,
    input  logic                                    cdb_ready_i,
    output cdb_pkg::rob_idx_t                       cdb_rob_idx_o,
    output logic                                    cdb_except_o,
    output cdb_pkg::cdb_payload_t                   cdb_payload_o,
    output logic                                    cdb_from_max_prio_o
);

    localparam int unsigned EU_N  = `CDB_EU_N;
    localparam int unsigned BUF_W = $clog2(EU_N);

    // Buffer 0 serves the maximum-priority unit
    // Ordinary unit k sits in buffer k+1
    logic [EU_N-1:0]                  in_valid;
    logic [EU_N-1:0]                  in_ready;
    cdb_pkg::rob_idx_t [EU_N-1:0]     in_rob_idx;
    logic [EU_N-1:0]                  in_except;
    cdb_pkg::cdb_payload_t [EU_N-1:0] in_payload;

    logic [EU_N-1:0]                  out_valid;
    logic [EU_N-1:0]                  out_ready;
    cdb_pkg::rob_idx_t [EU_N-1:0]     out_rob_idx;
    logic [EU_N-1:0]                  out_except;
    cdb_pkg::cdb_payload_t [EU_N-1:0] out_payload;

    // Arbiter select
    logic                             served_mp;
    cdb_pkg::unit_idx_t               served_idx;
    logic [BUF_W-1:0]                 buf_sel;

    // Flatten unit inputs into one array
    assign in_valid   = {eu_valid_i, mp_valid_i};
    assign in_rob_idx = {eu_rob_idx_i, mp_rob_idx_i};
    assign in_except  = {eu_except_i, mp_except_i};
    assign in_payload = {eu_payload_i, mp_payload_i};

    assign mp_ready_o = in_ready[0];
    assign eu_ready_o = in_ready[EU_N-1:1];

    // One result buffer per unit
    for (genvar g = 0; g < EU_N; g++) begin : g_buf
        eu_result_buf u_buf (
            .clk_i         (clk_i),
            .rst_n_i       (rst_n_i),
            .flush_i       (flush_i),
            .in_valid_i    (in_valid[g]),
            .in_ready_o    (in_ready[g]),
            .in_rob_idx_i  (in_rob_idx[g]),
            .in_except_i   (in_except[g]),
            .in_payload_i  (in_payload[g]),
            .out_valid_o   (out_valid[g]),
            .out_ready_i   (out_ready[g]),
            .out_rob_idx_o (out_rob_idx[g]),
            .out_except_o  (out_except[g]),
            .out_payload_o (out_payload[g])
        );
    end

    cdb_arbiter u_arbiter (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .max_prio_valid_i  (out_valid[0]),
        .max_prio_ready_o  (out_ready[0]),
        .valid_i           (out_valid[EU_N-1:1]),
        .ready_o           (out_ready[EU_N-1:1]),
        .rob_ready_i       (cdb_ready_i),
        .rob_valid_o       (cdb_valid_o),
        .served_max_prio_o (served_mp),
        .served_o          (served_idx)
    );

    // Map the arbiter choice onto a buffer number
    assign buf_sel = served_mp ? '0 : BUF_W'(served_idx) + 1'b1;

    // Data multiplexer towards the ROB
    // Contents are don't-care while cdb_valid_o is low
    assign cdb_rob_idx_o       = out_rob_idx[buf_sel];
    assign cdb_except_o        = out_except[buf_sel];
    assign cdb_payload_o       = out_payload[buf_sel];
    assign cdb_from_max_prio_o = served_mp;

endmodule

// ==== dv/tb_cdb.sv ====
`timescale 1ns/100ps
`include "cdb_defs.svh"

module tb_cdb;

    localparam int EU_N    = `CDB_EU_N;
    localparam int TIMEOUT = 5000;

    logic clk_i;
    logic rst_n_i;
    logic flush_i;
    logic cdb_ready_i;

    // Unit 0 is the maximum-priority unit, 1 and up the ordinary ones
    logic [EU_N-1:0]                  u_valid;
    logic [EU_N-1:0]                  u_ready;
    cdb_pkg::rob_idx_t [EU_N-1:0]     u_idx;
    logic [EU_N-1:0]                  u_exc;
    cdb_pkg::cdb_payload_t [EU_N-1:0] u_pl;

    logic                  mp_ready_o;
    logic [EU_N-2:0]       eu_ready_o;
    logic                  cdb_valid_o;
    cdb_pkg::rob_idx_t     cdb_rob_idx_o;
    logic                  cdb_except_o;
    cdb_pkg::cdb_payload_t cdb_payload_o;
    logic                  cdb_from_max_prio_o;

    // Stimulus knobs, written by the main sequence at rising edges
    integer          seed = 32'h584d1a34;
    int              issue_pct [EU_N];
    int              rob_pct;
    logic            issue_en;
    logic            fair_en;
    logic            flush_req;

    // Scoreboard state
    int              issued [EU_N];
    int              exp_q [EU_N][$];
    int              gap [EU_N];
    logic [EU_N-1:0] fired;
    int              errors;
    int              checks;
    int              delivered;
    int              tests_run;

    // Bus contents of the previous cycle for the stall check
    logic                  prev_stall;
    logic                  prev_flush;
    cdb_pkg::rob_idx_t     prev_idx;
    logic                  prev_exc;
    cdb_pkg::cdb_payload_t prev_pl;
    logic                  prev_mp;

    assign u_ready = {eu_ready_o, mp_ready_o};

    cdb_top uut (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .flush_i             (flush_i),
        .mp_valid_i          (u_valid[0]),
        .mp_ready_o          (mp_ready_o),
        .mp_rob_idx_i        (u_idx[0]),
        .mp_except_i         (u_exc[0]),
        .mp_payload_i        (u_pl[0]),
        .eu_valid_i          (u_valid[EU_N-1:1]),
        .eu_ready_o          (eu_ready_o),
        .eu_rob_idx_i        (u_idx[EU_N-1:1]),
        .eu_except_i         (u_exc[EU_N-1:1]),
        .eu_payload_i        (u_pl[EU_N-1:1]),
        .cdb_valid_o         (cdb_valid_o),
        .cdb_ready_i         (cdb_ready_i),
        .cdb_rob_idx_o       (cdb_rob_idx_o),
        .cdb_except_o        (cdb_except_o),
        .cdb_payload_o       (cdb_payload_o),
        .cdb_from_max_prio_o (cdb_from_max_prio_o)
    );

    initial begin : clk_gen
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Percent roll from the seeded generator
    function automatic int roll();
        roll = $unsigned($random(seed)) % 100;
    endfunction

    // Expected result for a unit's n-th issue
    // Unit number sits in the top two ROB index bits
    // Every fifth result or so is an exception
    function automatic void ref_result(input int unit, input int seq,
                                       output cdb_pkg::rob_idx_t idx,
                                       output logic exc,
                                       output cdb_pkg::cdb_payload_t pl);
        logic [31:0] u_w;
        logic [31:0] s_w;
        logic [31:0] mix;
        u_w = unit;
        s_w = seq;
        mix = u_w * 32'h0100_0193 ^ s_w * 32'h9E37_79B9;
        idx = {u_w[1:0], s_w[`CDB_ROB_IDX_W-3:0]};
        exc = ((s_w + u_w) % 5) == 3;
        pl  = '0;
        if (exc) begin
            pl.exc.cause = mix[`CDB_EXC_CAUSE_W-1:0];
            // Fake faulting address, low bits only
            pl.exc.tval  = {s_w[`CDB_EXC_TVAL_W-3:0], u_w[1:0]};
        end else begin
            pl.value = mix;
        end
    endfunction

    task automatic check_flag(input string name, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic check_rob_idx(input string name, input cdb_pkg::rob_idx_t exp,
                                 input cdb_pkg::rob_idx_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    // Decoding follows the exception flag
    task automatic check_payload(input string name, input logic exc,
                                 input cdb_pkg::cdb_payload_t exp,
                                 input cdb_pkg::cdb_payload_t got);
        checks++;
        if (exc) begin
            if (got.exc.cause !== exp.exc.cause || got.exc.tval !== exp.exc.tval) begin
                errors++;
                $display("** Error at %0t: %s expected cause %0d tval %h got cause %0d tval %h",
                         $time, name, exp.exc.cause, exp.exc.tval, got.exc.cause,
                         got.exc.tval);
            end
        end else if (got.value !== exp.value) begin
            errors++;
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp.value,
                     got.value);
        end
    endtask

    // Unit and ROB models, driven just after each rising edge
    always @(posedge clk_i) begin : stim_drive
        cdb_pkg::rob_idx_t     r_idx;
        logic                  r_exc;
        cdb_pkg::cdb_payload_t r_pl;
        #1;
        flush_i     = flush_req;
        cdb_ready_i = (roll() < rob_pct);
        for (int u = 0; u < EU_N; u++) begin
            // Accepted last edge, so the slot is free again
            if (fired[u]) begin
                u_valid[u] = 1'b0;
                fired[u]   = 1'b0;
            end
            if (!u_valid[u] && issue_en && roll() < issue_pct[u]) begin
                ref_result(u, issued[u], r_idx, r_exc, r_pl);
                u_idx[u]   = r_idx;
                u_exc[u]   = r_exc;
                u_pl[u]    = r_pl;
                u_valid[u] = 1'b1;
            end
        end
    end

    // Scoreboard, sampling at the falling edge where everything is settled
    always @(negedge clk_i) begin : monitor
        int                    unit;
        int                    seq;
        logic                  held;
        cdb_pkg::rob_idx_t     e_idx;
        logic                  e_exc;
        cdb_pkg::cdb_payload_t e_pl;
        if (!rst_n_i) begin
            prev_stall = 1'b0;
            prev_flush = 1'b0;
        end else begin
            held = prev_stall && !prev_flush;
            // A stalled result must stay on the bus unchanged
            if (held) begin
                check_flag("cdb_valid_o", 1'b1, cdb_valid_o);
                check_rob_idx("cdb_rob_idx_o", prev_idx, cdb_rob_idx_o);
                check_flag("cdb_except_o", prev_exc, cdb_except_o);
                check_payload("cdb_payload_o", prev_exc, prev_pl, cdb_payload_o);
                check_flag("cdb_from_max_prio_o", prev_mp, cdb_from_max_prio_o);
            end
            if (cdb_valid_o && cdb_ready_i) begin
                delivered++;
                unit = int'(cdb_rob_idx_o[`CDB_ROB_IDX_W-1 -: 2]);
                // Queue 0 holds only results accepted at earlier edges here
                if (unit != 0 && exp_q[0].size() > 0 && !held) begin
                    errors++;
                    $display("Preemption broken at %0t: unit %0d served, max-priority waits",
                             $time, unit);
                end
                if (exp_q[unit].size() == 0) begin
                    errors++;
                    $display("Unexpected CDB transfer at %0t: nothing outstanding for unit %0d",
                             $time, unit);
                end else begin
                    seq = exp_q[unit].pop_front();
                    ref_result(unit, seq, e_idx, e_exc, e_pl);
                    check_flag("cdb_from_max_prio_o", unit == 0, cdb_from_max_prio_o);
                    check_rob_idx("cdb_rob_idx_o", e_idx, cdb_rob_idx_o);
                    check_flag("cdb_except_o", e_exc, cdb_except_o);
                    check_payload("cdb_payload_o", e_exc, e_pl, cdb_payload_o);
                end
                // Count ordinary transfers since each unit was last served
                if (fair_en && unit != 0) begin
                    for (int u = 1; u < EU_N; u++) begin
                        if (u == unit) begin
                            gap[u] = 0;
                        end else begin
                            gap[u]++;
                            if (gap[u] >= EU_N) begin
                                errors++;
                                $display("Unfair at %0t: unit %0d skipped for %0d transfers",
                                         $time, u, gap[u]);
                            end
                        end
                    end
                end
            end
            // Unit-side acceptances, dropped when the flush edge discards them
            for (int u = 0; u < EU_N; u++) begin
                if (u_valid[u] && u_ready[u]) begin
                    if (!flush_i) begin
                        exp_q[u].push_back(issued[u]);
                    end
                    issued[u]++;
                    fired[u] = 1'b1;
                end
            end
            if (flush_i) begin
                for (int u = 0; u < EU_N; u++) begin
                    exp_q[u].delete();
                end
            end
            prev_stall = cdb_valid_o && !cdb_ready_i;
            prev_flush = flush_i;
            prev_idx   = cdb_rob_idx_o;
            prev_exc   = cdb_except_o;
            prev_pl    = cdb_payload_o;
            prev_mp    = cdb_from_max_prio_o;
        end
    end

    task automatic check_idle();
        check_flag("cdb_valid_o", 1'b0, cdb_valid_o);
        check_flag("mp_ready_o", 1'b1, mp_ready_o);
        for (int u = 0; u < EU_N - 1; u++) begin
            check_flag("eu_ready_o", 1'b1, eu_ready_o[u]);
        end
    endtask

    task automatic wait_transfers(input int n);
        int target;
        int cyc;
        target = delivered + n;
        cyc    = 0;
        while (delivered < target && cyc < TIMEOUT) begin
            @(posedge clk_i);
            cyc++;
        end
        if (delivered < target) begin
            errors++;
            $display("Timeout at %0t: %0d transfers still missing", $time, target - delivered);
        end
    endtask

    // Nothing held by a unit and nothing left in the scoreboard
    function automatic logic all_delivered();
        all_delivered = (u_valid == '0);
        for (int u = 0; u < EU_N; u++) begin
            if (exp_q[u].size() != 0) begin
                all_delivered = 1'b0;
            end
        end
    endfunction

    task automatic drain();
        int cyc;
        issue_en = 1'b0;
        cyc      = 0;
        while (!all_delivered() && cyc < TIMEOUT) begin
            @(posedge clk_i);
            cyc++;
        end
        if (!all_delivered()) begin
            errors++;
            $display("Timeout at %0t: results lost or stuck while draining", $time);
        end
        // Room for a stray extra transfer to show up
        repeat (4) @(posedge clk_i);
    endtask

    task automatic report_test(input string name, input int err0, input int xfer0);
        tests_run++;
        $display("test %-10s %s, %0d transfers, %0d errors", name,
                 (errors == err0) ? "pass" : "fail", delivered - xfer0, errors - err0);
    endtask

    task automatic run_phase(input string name, input int mp_pct, input int ord_pct,
                             input int rdy_pct, input int count, input logic fair,
                             input logic do_flush);
        int err0;
        int xfer0;
        @(posedge clk_i);
        err0         = errors;
        xfer0        = delivered;
        issue_pct[0] = mp_pct;
        for (int u = 1; u < EU_N; u++) begin
            issue_pct[u] = ord_pct;
            gap[u]       = 0;
        end
        rob_pct  = rdy_pct;
        fair_en  = fair;
        issue_en = 1'b1;
        if (do_flush) begin
            wait_transfers(count / 2);
            // One-cycle flush in the middle of traffic
            flush_req = 1'b1;
            @(posedge clk_i);
            flush_req = 1'b0;
        end
        wait_transfers(count);
        fair_en = 1'b0;
        drain();
        report_test(name, err0, xfer0);
    endtask

    initial begin : main
        int err0;
        rst_n_i     = 1'b0;
        flush_i     = 1'b0;
        cdb_ready_i = 1'b0;
        u_valid     = '0;
        u_idx       = '0;
        u_exc       = '0;
        u_pl        = '0;
        fired       = '0;
        issue_en    = 1'b0;
        fair_en     = 1'b0;
        flush_req   = 1'b0;
        rob_pct     = 50;
        errors      = 0;
        checks      = 0;
        delivered   = 0;
        tests_run   = 0;
        for (int u = 0; u < EU_N; u++) begin
            issue_pct[u] = 0;
            issued[u]    = 0;
            gap[u]       = 0;
        end

        err0 = errors;
        repeat (8) begin
            @(negedge clk_i);
            check_idle();
        end
        @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        repeat (2) begin
            @(negedge clk_i);
            check_idle();
        end
        report_test("reset", err0, 0);

        run_phase("random", 30, 40, 70, 200, 1'b0, 1'b0);
        run_phase("preempt", 70, 90, 90, 200, 1'b0, 1'b0);
        run_phase("backpress", 40, 60, 15, 150, 1'b0, 1'b0);
        run_phase("fairness", 0, 100, 100, 120, 1'b1, 1'b0);
        run_phase("flush", 40, 60, 60, 120, 1'b0, 1'b1);

        $display("%0d tests, %0d transfers, %0d checks, %0d errors", tests_run, delivered,
                 checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hw
hw/cdb_pkg.sv
hw/prio_enc.sv
hw/cdb_arbiter.sv
hw/eu_result_buf.sv
hw/cdb_top.sv
dv/tb_cdb.sv

// ==== run_verilator.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    -f all.f \
    --top-module tb_cdb \
    -Mdir obj_dir \
    -o tb_cdb_sim

out=$(./obj_dir/tb_cdb_sim)
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
else
    exit 1
fi
